/* common/common.sv */
package common;

        ////////////////////
        // Widths
        ////////////////////

        typedef logic [31:0] xlen_t;    // Data word
        typedef logic [31:0] addr_t;    // Byte address
        typedef logic [4:0]  reg_idx_t;

        typedef enum logic [2:0] {
                R_TYPE,
                I_TYPE,
                S_TYPE,
                B_TYPE,
                U_TYPE,
                J_TYPE,
                OTHER_TYPE
        } instruction_op_type;

        typedef enum logic [3:0] {
                ADD,
                SUB,
                SLL,
                SLT,
                SLTU,
                XOR,
                SRL,
                SRA,
                OR,
                AND,
                PASS_B          // LUI
        } alu_op_t;

        ////////////////////
        // Opcodes
        ////////////////////

        localparam logic [6:0] OP      = 7'b0110011;
        localparam logic [6:0] OP_IMM  = 7'b0010011;
        localparam logic [6:0] LOAD    = 7'b0000011;
        localparam logic [6:0] LOAD_FP = 7'b0000111;
        localparam logic [6:0] STORE   = 7'b0100011;
        localparam logic [6:0] BRANCH  = 7'b1100011;
        localparam logic [6:0] U_LUI   = 7'b0110111;
        localparam logic [6:0] U_AUIPC = 7'b0010111;
        localparam logic [6:0] JAL     = 7'b1101111;
        localparam logic [6:0] JALR    = 7'b1100111;

        // Branch funct3
        localparam logic [2:0] BEQ  = 3'b000;
        localparam logic [2:0] BNE  = 3'b001;
        localparam logic [2:0] BLT  = 3'b100;
        localparam logic [2:0] BGE  = 3'b101;
        localparam logic [2:0] BLTU = 3'b110;
        localparam logic [2:0] BGEU = 3'b111;

        localparam int    DMEM_WORDS = 256;
        localparam addr_t RESET_PC   = 32'h0000_0000;

endpackage

/* verilog/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import common::*; (
        input  xlen_t              instr,

        output logic [6:0]         opcode,
        output logic [2:0]         funct3,
        output logic               funct7_5,
        output reg_idx_t           rs1,
        output reg_idx_t           rs2,
        output reg_idx_t           rd,
        output instruction_op_type optype,
        output xlen_t              imm,
        output alu_op_t            alu_op
);

assign opcode   = instr[6:0];
assign funct3   = instr[14:12];
assign funct7_5 = instr[30];
assign rs1      = instr[19:15];
assign rs2      = instr[24:20];
assign rd       = instr[11:7];

always_comb
begin
        case (opcode)
                OP:                     optype = R_TYPE;
                OP_IMM, LOAD, LOAD_FP:  optype = I_TYPE;
                STORE:                  optype = S_TYPE;
                BRANCH:                 optype = B_TYPE;
                U_LUI, U_AUIPC:         optype = U_TYPE;
                JAL:                    optype = J_TYPE;
                default:                optype = OTHER_TYPE;    // JALR lands here
        endcase
end

always_comb
begin
        case (optype)
                I_TYPE:  imm = {{20{instr[31]}}, instr[31:20]};
                S_TYPE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                B_TYPE:  imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                instr[11:8], 1'b0};
                U_TYPE:  imm = {instr[31:12], 12'b0};
                J_TYPE:  imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
                default: imm = '0;
        endcase
end

always_comb
begin
        alu_op = ADD;   // Loads, stores, default
        if (opcode == OP || opcode == OP_IMM)
        begin
                case (funct3)
                        3'b000:  alu_op = (opcode == OP && funct7_5) ? SUB : ADD;
                        3'b001:  alu_op = SLL;
                        3'b010:  alu_op = SLT;
                        3'b011:  alu_op = SLTU;
                        3'b100:  alu_op = XOR;
                        3'b101:  alu_op = funct7_5 ? SRA : SRL;
                        3'b110:  alu_op = OR;
                        default: alu_op = AND;
                endcase
        end
        else if (opcode == U_LUI)
        begin
                alu_op = PASS_B;
        end
end

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ps

module control_unit import common::*; (
        input  logic [6:0]         opcode,
        input  instruction_op_type optype,
        input  logic [2:0]         funct3,
        input  xlen_t              rs1_data,
        input  xlen_t              rs2_data,

        output logic               ctrl_mem_write,
        output logic               ctrl_mem2reg,
        output logic               ctrl_reg_write,

        output logic               ctrl_alu_src,

        output logic               ctrl_is_branch,
        output logic               ctrl_branch_taken,
        output logic               ctrl_link
);

logic zero_flag;
logic lt_flag;
logic ltu_flag;

assign zero_flag = (rs1_data == rs2_data);
assign lt_flag   = ($signed(rs1_data) < $signed(rs2_data));
assign ltu_flag  = (rs1_data < rs2_data);       // Vectors are unsigned

always_comb
begin
        ctrl_mem_write    = 1'b0;
        ctrl_mem2reg      = 1'b0;
        ctrl_reg_write    = 1'b0;
        ctrl_alu_src      = 1'b0;
        ctrl_is_branch    = 1'b0;
        ctrl_branch_taken = 1'b0;
        ctrl_link         = 1'b0;

        case (optype)
                R_TYPE:
                        ctrl_reg_write = 1'b1;
                I_TYPE:
                begin
                        ctrl_reg_write = 1'b1;
                        ctrl_alu_src   = 1'b1;
                        if (opcode == LOAD || opcode == LOAD_FP)
                                ctrl_mem2reg = 1'b1;
                end
                S_TYPE:
                begin
                        ctrl_alu_src   = 1'b1;
                        ctrl_mem_write = 1'b1;
                end
                B_TYPE:
                begin
                        ctrl_is_branch = 1'b1;
                        case (funct3)
                                BEQ:     ctrl_branch_taken = zero_flag;
                                BNE:     ctrl_branch_taken = !zero_flag;
                                BLT:     ctrl_branch_taken = lt_flag;
                                BGE:     ctrl_branch_taken = !lt_flag;
                                BLTU:    ctrl_branch_taken = ltu_flag;
                                BGEU:    ctrl_branch_taken = !ltu_flag;
                                default: ctrl_branch_taken = 1'b0;
                        endcase
                end
                U_TYPE:
                        if (opcode == U_LUI)    // AUIPC retires as no-op
                        begin
                                ctrl_reg_write = 1'b1;
                                ctrl_alu_src   = 1'b1;
                        end
                J_TYPE:
                begin
                        ctrl_branch_taken = 1'b1;
                        ctrl_link         = 1'b1;
                        ctrl_reg_write    = 1'b1;
                end
                default:
                        ctrl_reg_write = 1'b0;
        endcase
end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import common::*; (
        input  alu_op_t alu_op,
        input  xlen_t   a,
        input  xlen_t   b,

        output xlen_t   y
);

logic [4:0] shamt;

assign shamt = b[4:0];

always_comb
begin
        case (alu_op)
                ADD:     y = a + b;
                SUB:     y = a - b;
                SLL:     y = a << shamt;
                SLT:     y = {31'b0, $signed(a) < $signed(b)};
                SLTU:    y = {31'b0, a < b};
                XOR:     y = a ^ b;
                SRL:     y = a >> shamt;
                SRA:     y = xlen_t'($signed(a) >>> shamt);       // Keeps sign
                OR:      y = a | b;
                AND:     y = a & b;
                PASS_B:  y = b;
                default: y = '0;
        endcase
end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file import common::*; (
        input  logic     clk,
        input  logic     arst_n,
        input  reg_idx_t rs1,
        input  reg_idx_t rs2,
        input  logic     we,
        input  reg_idx_t rd,
        input  xlen_t    wdata,

        output xlen_t    rs1_data,
        output xlen_t    rs2_data
);

xlen_t regs [32];

assign rs1_data = regs[rs1];
assign rs2_data = regs[rs2];

always_ff @(posedge clk or negedge arst_n)
begin
        if (!arst_n)
        begin
                for (int i = 0; i < 32; i++)
                        regs[i] <= '0;
        end
        else if (we && rd != 5'd0)      // x0 stays zero
        begin
                regs[rd] <= wdata;
        end
end

endmodule

/* verilog/data_mem.sv */
`timescale 1ns/1ps

module data_mem import common::*; (
        input  logic  clk,
        input  logic  arst_n,
        input  addr_t addr,
        input  logic  we,
        input  xlen_t wdata,

        output xlen_t rdata
);

xlen_t      mem [DMEM_WORDS];
logic [7:0] idx;

assign idx   = addr[9:2];       // Word index
assign rdata = mem[idx];

always_ff @(posedge clk or negedge arst_n)
begin
        if (!arst_n)
        begin
                for (int i = 0; i < DMEM_WORDS; i++)
                        mem[i] <= '0;
        end
        else if (we)
        begin
                mem[idx] <= wdata;
        end
end

endmodule

/* verilog/issue_sequencer.sv */
`timescale 1ns/1ps

module issue_sequencer import common::*; (
        input  logic     clk,
        input  logic     arst_n,
        input  logic     instr_valid,
        input  logic     retire_ready,
        input  logic     ctrl_branch_taken,
        input  logic     ctrl_link,
        input  logic     ctrl_reg_write,
        input  xlen_t    imm,
        input  reg_idx_t rd,
        input  xlen_t    result,

        output addr_t    pc,
        output logic     instr_ready,
        output logic     fire,
        output xlen_t    link_data,
        output logic     retire_valid,
        output addr_t    retire_pc,
        output reg_idx_t retire_rd,
        output logic     retire_we,
        output xlen_t    retire_data,
        output addr_t    retire_next_pc
);

addr_t next_pc;
logic  rd_write;

////////////////////
// Handshake
////////////////////

assign instr_ready = !retire_valid || retire_ready;     // Slot frees as record leaves
assign fire        = instr_valid && instr_ready;

assign link_data = pc + 32'd4;
assign next_pc   = ctrl_branch_taken ? pc + imm : link_data;    // JAL or taken branch
assign rd_write  = ctrl_reg_write && (rd != 5'd0);

always_ff @(posedge clk or negedge arst_n)
begin
        if (!arst_n)
        begin
                pc           <= RESET_PC;
                retire_valid <= 1'b0;
                retire_we    <= 1'b0;
        end
        else if (fire)
        begin
                pc           <= next_pc;
                retire_valid <= 1'b1;
                retire_we    <= rd_write;
        end
        else if (retire_ready)
        begin
                retire_valid <= 1'b0;
        end
end

////////////////////
// Retire record
////////////////////

always_ff @(posedge clk)
begin
        if (fire)
        begin
                retire_pc      <= pc;
                retire_rd      <= rd;
                retire_data    <= rd_write ? result : '0;
                retire_next_pc <= next_pc;
        end
end

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps

module rv_core import common::*; (
        input  logic     clk,
        input  logic     arst_n,
        input  logic     instr_valid,
        input  xlen_t    instr,
        input  logic     retire_ready,

        output logic     instr_ready,
        output addr_t    pc,
        output logic     retire_valid,
        output addr_t    retire_pc,
        output reg_idx_t retire_rd,
        output logic     retire_we,
        output xlen_t    retire_data,
        output addr_t    retire_next_pc
);

logic [6:0]         opcode;
logic [2:0]         funct3;
reg_idx_t           rs1, rs2, rd;
instruction_op_type optype;
xlen_t              imm;
alu_op_t            alu_op;

logic  ctrl_mem_write, ctrl_mem2reg, ctrl_reg_write, ctrl_alu_src;
logic  ctrl_branch_taken, ctrl_link;
logic  fire;
xlen_t rs1_data, rs2_data, alu_b, alu_y, mem_rdata, link_data, wb_data;

////////////////////
// Datapath muxes
////////////////////

assign alu_b   = ctrl_alu_src ? imm : rs2_data;
assign wb_data = ctrl_link ? link_data : (ctrl_mem2reg ? mem_rdata : alu_y);

issue_sequencer seq0 (
        .clk               (clk),
        .arst_n            (arst_n),
        .instr_valid       (instr_valid),
        .retire_ready      (retire_ready),
        .ctrl_branch_taken (ctrl_branch_taken),
        .ctrl_link         (ctrl_link),
        .ctrl_reg_write    (ctrl_reg_write),
        .imm               (imm),
        .rd                (rd),
        .result            (wb_data),
        .pc                (pc),
        .instr_ready       (instr_ready),
        .fire              (fire),
        .link_data         (link_data),
        .retire_valid      (retire_valid),
        .retire_pc         (retire_pc),
        .retire_rd         (retire_rd),
        .retire_we         (retire_we),
        .retire_data       (retire_data),
        .retire_next_pc    (retire_next_pc)
);

instr_decode dec0 (
        .instr    (instr),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7_5 (),           // Consumed inside the decoder
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .optype   (optype),
        .imm      (imm),
        .alu_op   (alu_op)
);

control_unit ctrl0 (
        .opcode            (opcode),
        .optype            (optype),
        .funct3            (funct3),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .ctrl_mem_write    (ctrl_mem_write),
        .ctrl_mem2reg      (ctrl_mem2reg),
        .ctrl_reg_write    (ctrl_reg_write),
        .ctrl_alu_src      (ctrl_alu_src),
        .ctrl_is_branch    (),
        .ctrl_branch_taken (ctrl_branch_taken),
        .ctrl_link         (ctrl_link)
);

reg_file rf0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .we       (fire && ctrl_reg_write),
        .rd       (rd),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
);

alu alu0 (
        .alu_op (alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .y      (alu_y)
);

data_mem dmem0 (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (alu_y),        // Base plus offset
        .we     (fire && ctrl_mem_write),
        .wdata  (rs2_data),
        .rdata  (mem_rdata)
);

endmodule

/* tests/rv_core_props.sv */
`timescale 1ns/1ps

module rv_core_props import common::*; (
        input logic     clk,
        input logic     arst_n,
        input addr_t    pc,
        input logic     instr_ready,
        input logic     retire_valid,
        input logic     retire_ready,
        input addr_t    retire_pc,
        input reg_idx_t retire_rd,
        input logic     retire_we,
        input xlen_t    retire_data,
        input addr_t    retire_next_pc
);

// Stalled record holds
record_stable: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
                && $stable(retire_rd) && $stable(retire_we)
                && $stable(retire_data) && $stable(retire_next_pc))
        else $error("retire record changed while stalled");

// Stalled core takes no instruction and keeps its pc
no_issue_when_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && !retire_ready |=> !$past(instr_ready) && $stable(pc))
        else $error("instruction taken while the retire slot is stalled");

no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && retire_we |-> retire_rd != 5'd0)
        else $error("retire record writes register x0");

endmodule

bind issue_sequencer rv_core_props props0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc             (pc),
        .instr_ready    (instr_ready),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_we      (retire_we),
        .retire_data    (retire_data),
        .retire_next_pc (retire_next_pc)
);

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb import common::*; ();

logic     clk;
logic     arst_n;
logic     instr_valid;
xlen_t    instr;
logic     retire_ready;
logic     instr_ready;
addr_t    pc;
logic     retire_valid;
addr_t    retire_pc;
reg_idx_t retire_rd;
logic     retire_we;
xlen_t    retire_data;
addr_t    retire_next_pc;

integer seed;
int     errors;
int     tests_run;
int     tests_failed;
int     n_rec;
bit     timed_out;

// Trace records, one entry per instruction
int    rec_grp[$];
xlen_t rec_instr[$];
addr_t rec_pc[$];
xlen_t rec_rd[$];
xlen_t rec_we[$];
xlen_t rec_data[$];
addr_t rec_next[$];

rv_core dut0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .retire_ready   (retire_ready),
        .instr_ready    (instr_ready),
        .pc             (pc),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_we      (retire_we),
        .retire_data    (retire_data),
        .retire_next_pc (retire_next_pc)
);

initial
begin
        clk = 1'b0;
        forever #50 clk = ~clk;
end

////////////////////
// Helpers
////////////////////

function automatic string test_name(input int g);
        case (g)
                1:       return "alu";
                2:       return "lui_mem";
                3:       return "branch";
                4:       return "jal";
                default: return "misc";
        endcase
endfunction

task automatic compare_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp)
        begin
                errors++;
                $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
endtask

task automatic report_test(input string name, input string mode, input int err0);
        tests_run++;
        if (errors == err0)
        begin
                $display("test %s (%s): ok", name, mode);
        end
        else
        begin
                tests_failed++;
                $display("test %s (%s): %0d errors", name, mode, errors - err0);
        end
endtask

task automatic load_stimulus();
        int    fd;
        int    g;
        xlen_t w, p, r, wen, d, nx;
        fd = $fopen("tests/rv_core_stimulus.txt", "r");
        if (fd == 0)
        begin
                errors++;
                $display("Cannot open tests/rv_core_stimulus.txt");
                return;
        end
        while ($fscanf(fd, "%d %h %h %h %h %h %h\n", g, w, p, r, wen, d, nx) == 7)
        begin
                rec_grp.push_back(g);
                rec_instr.push_back(w);
                rec_pc.push_back(p);
                rec_rd.push_back(r);
                rec_we.push_back(wen);
                rec_data.push_back(d);
                rec_next.push_back(nx);
        end
        $fclose(fd);
        n_rec = rec_instr.size();
        if (n_rec == 0)
        begin
                errors++;
                $display("No records found in the stimulus file");
        end
endtask

task automatic apply_reset(input string mode);
        int err0;
        err0         = errors;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        retire_ready = 1'b0;
        repeat (8) @(posedge clk);
        #5;
        arst_n = 1'b1;
        #1;
        if (retire_valid !== 1'b0)
        begin
                errors++;
                $display("** Error at %0t ns: retire_valid = %b, expected 0", $time, retire_valid);
        end
        compare_word("pc", pc, RESET_PC);
        report_test("reset", mode, err0);
endtask

task automatic check_record(input int k);
        compare_word("retire_pc", retire_pc, rec_pc[k]);
        compare_word("retire_rd", {27'b0, retire_rd}, rec_rd[k]);
        compare_word("retire_we", {31'b0, retire_we}, rec_we[k]);
        compare_word("retire_data", retire_data, rec_data[k]);
        compare_word("retire_next_pc", retire_next_pc, rec_next[k]);
endtask

////////////////////
// Trace runner
////////////////////

task automatic run_trace(input bit pressure, input string mode);
        int iss;
        int ret;
        int wait_issue;
        int wait_retire;
        int grp_err;
        iss         = 0;
        ret         = 0;
        wait_issue  = 0;
        wait_retire = 0;
        grp_err     = errors;
        while (ret < n_rec && !timed_out)
        begin
                @(posedge clk);
                #5;
                retire_ready = pressure ? (($random(seed) & 3) != 0) : 1'b1;
                instr_valid  = (iss < n_rec);
                instr        = (iss < n_rec) ? rec_instr[iss] : '0;
                #1;     // Outputs settled, next edge takes them
                if (instr_valid && instr_ready)
                begin
                        compare_word("pc", pc, rec_pc[iss]);
                        iss++;
                        wait_issue = 0;
                end
                else if (instr_valid)
                begin
                        wait_issue++;
                end
                if (retire_valid && retire_ready)
                begin
                        check_record(ret);
                        ret++;
                        wait_retire = 0;
                        if (ret < n_rec && rec_grp[ret] != rec_grp[ret - 1])
                        begin
                                report_test(test_name(rec_grp[ret - 1]), mode, grp_err);
                                grp_err = errors;
                        end
                end
                else
                begin
                        wait_retire++;
                end
                if (wait_issue > 200 || wait_retire > 200)
                begin
                        errors++;
                        timed_out = 1'b1;
                        $display("Timeout after 200 cycles waiting for instr_ready or retire_valid");
                end
        end
        if (!timed_out && n_rec > 0)
        begin
                @(posedge clk);
                #5;
                instr_valid = 1'b0;
                #1;
                if (retire_valid)
                begin
                        errors++;
                        $display("Extra retire record after the last instruction at %0t ns", $time);
                end
                report_test(test_name(rec_grp[n_rec - 1]), mode, grp_err);
        end
endtask

initial
begin
        seed         = 32'h9a92;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        n_rec        = 0;
        timed_out    = 1'b0;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        retire_ready = 1'b0;

        load_stimulus();
        apply_reset("ready high");
        run_trace(1'b0, "ready high");
        if (!timed_out)
        begin
                apply_reset("back-pressure");
                run_trace(1'b1, "back-pressure");
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
                $display("** PASS **");
        else
                $display("** FAIL **");
        $finish;
end

endmodule

/* tests/rv_core_stimulus.txt */
1 00500093 00000000 01 1 00000005 00000004
1 ffd00113 00000004 02 1 fffffffd 00000008
1 002081b3 00000008 03 1 00000002 0000000c
1 40208233 0000000c 04 1 00000008 00000010
1 0020c2b3 00000010 05 1 fffffff8 00000014
1 0020e333 00000014 06 1 fffffffd 00000018
1 0020f3b3 00000018 07 1 00000005 0000001c
1 00109433 0000001c 08 1 000000a0 00000020
1 401154b3 00000020 09 1 ffffffff 00000024
1 00115533 00000024 0a 1 07ffffff 00000028
1 001125b3 00000028 0b 1 00000001 0000002c
1 00113633 0000002c 0c 1 00000000 00000030
1 40115693 00000030 0d 1 fffffffe 00000034
1 fff0b713 00000034 0e 1 00000001 00000038
2 123457b7 00000038 0f 1 12345000 0000003c
2 67878793 0000003c 0f 1 12345678 00000040
2 00f02823 00000040 10 0 00000000 00000044
2 01002803 00000044 10 1 12345678 00000048
2 01402983 00000048 13 1 00000000 0000004c
2 00700013 0000004c 00 0 00000000 00000050
3 00108463 00000050 08 0 00000000 00000058
3 00208463 00000058 08 0 00000000 0000005c
3 00209463 0000005c 08 0 00000000 00000064
3 00109463 00000064 08 0 00000000 00000068
3 00114463 00000068 08 0 00000000 00000070
3 0020c463 00000070 08 0 00000000 00000074
3 0020d463 00000074 08 0 00000000 0000007c
3 00115463 0000007c 08 0 00000000 00000080
3 0020e463 00000080 08 0 00000000 00000088
3 00116463 00000088 08 0 00000000 0000008c
3 00117463 0000008c 08 0 00000000 00000094
3 0020f463 00000094 08 0 00000000 00000098
4 010008ef 00000098 11 1 0000009c 000000a8
4 ff9ff06f 000000a8 00 0 00000000 000000a0
4 00f88933 000000a0 12 1 12345714 000000a4
4 00001a17 000000a4 14 0 00000000 000000a8

/* rv_core.f */
common/common.sv
verilog/instr_decode.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/data_mem.sv
verilog/issue_sequencer.sv
verilog/rv_core.sv
tests/rv_core_props.sv
tests/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"
echo "$out" | grep -Fqx '** PASS **'
